// ==== common/debugger_pkg.sv ====
package debugger_pkg;

    // Host command opcodes
    typedef enum logic [7:0] {
        CMD_MEM_READ    = 8'h01,
        CMD_MEM_WRITE   = 8'h02,
        CMD_VALUE_READ  = 8'h03,
        CMD_VALUE_WRITE = 8'h04
    } cmd_e;

    // Value identifiers for the register block
    typedef enum logic [7:0] {
        VAL_A          = 8'd0,
        VAL_PC         = 8'd1,
        VAL_IR         = 8'd2,
        VAL_STEP_COUNT = 8'd3,
        VAL_CONTROL    = 8'd4
    } value_id_e;

    // Target CPU opcodes, anything else runs as a 1-byte NOP
    typedef enum logic [7:0] {
        OP_LDA_IMM = 8'hA9,
        OP_ADC_IMM = 8'h69,
        OP_STA_ABS = 8'h8D,
        OP_JMP_ABS = 8'h4C
    } cpu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_OPLO,
        ST_OPHI,
        ST_EXEC,
        ST_DONE
    } cpu_state_e;

    // Command parser FSM
    typedef enum logic [2:0] {
        CS_OPCODE,
        CS_ARGS,
        CS_ISSUE,
        CS_WAIT,
        CS_SEND_HI,
        CS_SEND_LO
    } cmd_state_e;

    localparam logic [7:0] VALUE_WRITE_ACK = 8'h5A;

    // VAL_CONTROL bit positions
    localparam int CTRL_STEP_BIT = 0;
    localparam int CTRL_HOLD_BIT = 1;

endpackage

// ==== rtl/debug_memory.sv ====
module debug_memory #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic        i_clk_5mhz,
    input  logic        i_reset_n,

    input  logic        i_cpu_en,
    input  logic        i_cpu_rw,       // 1 read, 0 write
    input  logic [15:0] i_cpu_addr,
    input  logic [7:0]  i_cpu_wdata,
    output logic [7:0]  o_cpu_rdata,

    input  logic        i_dbg_en,
    input  logic        i_dbg_rw,
    input  logic [15:0] i_dbg_addr,
    input  logic [7:0]  i_dbg_wdata,
    output logic [7:0]  o_dbg_rdata,
    output logic        o_dbg_grant
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [7:0]            r_mem [DEPTH];
    logic [ADDR_WIDTH-1:0] w_addr;
    logic [7:0]            w_wdata;
    logic                  w_we;

    // Single port, the CPU always wins
    assign o_dbg_grant = i_dbg_en && !i_cpu_en;
    assign w_addr  = i_cpu_en ? i_cpu_addr[ADDR_WIDTH-1:0] : i_dbg_addr[ADDR_WIDTH-1:0];
    assign w_wdata = i_cpu_en ? i_cpu_wdata : i_dbg_wdata;
    assign w_we    = i_cpu_en ? !i_cpu_rw : (o_dbg_grant && !i_dbg_rw);

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < DEPTH; i++)
                r_mem[i] <= 8'h00;
        end
        else if (w_we)
        begin
            r_mem[w_addr] <= w_wdata;
        end
    end

    // Each requester keeps its own read register
    always_ff @(posedge i_clk_5mhz)
    begin
        if (i_cpu_en && i_cpu_rw)
            o_cpu_rdata <= r_mem[w_addr];
        if (o_dbg_grant && i_dbg_rw)
            o_dbg_rdata <= r_mem[w_addr];
    end

    // A refused debugger request waits unchanged for its grant
    a_dbg_held_until_grant: assert property (
        @(posedge i_clk_5mhz) disable iff (!i_reset_n)
        (i_dbg_en && !o_dbg_grant) |=> (i_dbg_en && $stable(i_dbg_addr) && $stable(i_dbg_rw))
    );

endmodule

// ==== rtl/step_cpu.sv ====
module step_cpu #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic        i_clk_5mhz,
    input  logic        i_reset_n,

    input  logic        i_step,
    input  logic        i_hold_reset,

    output logic        o_mem_en,
    output logic        o_mem_rw,       // 1 read, 0 write
    output logic [15:0] o_mem_addr,
    output logic [7:0]  o_mem_wdata,
    input  logic [7:0]  i_mem_rdata,

    output logic [7:0]  o_a,
    output logic [15:0] o_pc,
    output logic [7:0]  o_ir,
    output logic        o_busy,
    output logic        o_step_done
);

    import debugger_pkg::*;

    localparam logic [15:0] ADDR_MASK = 16'((32'd1 << ADDR_WIDTH) - 1);

    cpu_state_e  r_state;
    logic        r_phase;   // 0 takes the byte just read, 1 requests the next one
    logic [7:0]  r_oplo;
    logic [15:0] w_addr;

    function automatic logic [1:0] op_length(input logic [7:0] op);
        case (cpu_op_e'(op))
            OP_LDA_IMM, OP_ADC_IMM: return 2'd2;
            OP_STA_ABS, OP_JMP_ABS: return 2'd3;
            default:                return 2'd1;
        endcase
    endfunction

    assign o_busy      = (r_state != ST_IDLE);
    assign o_step_done = (r_state == ST_DONE);
    assign o_mem_wdata = o_a;
    assign o_mem_addr  = w_addr & ADDR_MASK;

    always_comb
    begin
        o_mem_en = 1'b0;
        o_mem_rw = 1'b1;
        w_addr   = o_pc;
        case (r_state)
            ST_FETCH: o_mem_en = 1'b1;
            ST_OPLO:
            begin
                o_mem_en = r_phase;
                w_addr   = o_pc + 16'd1;
            end
            ST_OPHI:
            begin
                o_mem_en = r_phase;
                w_addr   = o_pc + 16'd2;
            end
            ST_EXEC:
            begin
                // High address byte arrives in this cycle
                if (o_ir == OP_STA_ABS)
                begin
                    o_mem_en = 1'b1;
                    o_mem_rw = 1'b0;
                    w_addr   = {i_mem_rdata, r_oplo};
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            r_state <= ST_IDLE;
            r_phase <= 1'b0;
            r_oplo  <= '0;
            o_a     <= '0;
            o_pc    <= '0;
            o_ir    <= '0;
        end
        else if (i_hold_reset)
        begin
            // Held CPU keeps its registers at zero
            r_state <= ST_IDLE;
            r_phase <= 1'b0;
            r_oplo  <= '0;
            o_a     <= '0;
            o_pc    <= '0;
            o_ir    <= '0;
        end
        else
        begin
            case (r_state)
                ST_IDLE:  if (i_step) r_state <= ST_FETCH;
                ST_FETCH: r_state <= ST_OPLO;
                ST_OPLO:
                begin
                    if (!r_phase)
                    begin
                        o_ir <= i_mem_rdata;
                        if (op_length(i_mem_rdata) == 2'd1)
                        begin
                            o_pc    <= o_pc + 16'd1;    // NOP
                            r_state <= ST_DONE;
                        end
                        else
                            r_phase <= 1'b1;
                    end
                    else
                    begin
                        r_phase <= 1'b0;
                        r_state <= (op_length(o_ir) == 2'd2) ? ST_EXEC : ST_OPHI;
                    end
                end
                ST_OPHI:
                begin
                    if (!r_phase)
                        r_oplo <= i_mem_rdata;
                    else
                        r_state <= ST_EXEC;
                    r_phase <= !r_phase;
                end
                ST_EXEC:
                begin
                    r_state <= ST_DONE;
                    case (cpu_op_e'(o_ir))
                        OP_LDA_IMM:
                        begin
                            o_a  <= i_mem_rdata;
                            o_pc <= o_pc + 16'd2;
                        end
                        OP_ADC_IMM:
                        begin
                            o_a  <= o_a + i_mem_rdata;   // No carry in, wraps
                            o_pc <= o_pc + 16'd2;
                        end
                        OP_JMP_ABS: o_pc <= {i_mem_rdata, r_oplo};
                        default:    o_pc <= o_pc + 16'd3;
                    endcase
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== debugger/debugger_values.sv ====
module debugger_values (
    input  logic        i_clk_5mhz,
    input  logic        i_reset_n,

    input  logic        i_value_en,
    input  logic        i_value_we,
    input  logic [7:0]  i_value_id,
    input  logic [15:0] i_value_wdata,
    output logic [15:0] o_value_rdata,

    input  logic [7:0]  i_cpu_a,
    input  logic [15:0] i_cpu_pc,
    input  logic [7:0]  i_cpu_ir,
    input  logic        i_cpu_busy,
    input  logic        i_step_done,

    output logic        o_cpu_step,
    output logic        o_cpu_hold_reset
);

    import debugger_pkg::*;

    logic [15:0] r_step_count;
    logic        w_ctrl_write;

    assign w_ctrl_write = i_value_en && i_value_we && (i_value_id == VAL_CONTROL);

    // Combinational read, unknown ids return zero
    always_comb
    begin
        o_value_rdata = '0;
        if (i_value_en)
        begin
            case (value_id_e'(i_value_id))
                VAL_A:          o_value_rdata = {8'h00, i_cpu_a};
                VAL_PC:         o_value_rdata = i_cpu_pc;
                VAL_IR:         o_value_rdata = {8'h00, i_cpu_ir};
                VAL_STEP_COUNT: o_value_rdata = r_step_count;
                VAL_CONTROL:    o_value_rdata = {14'h0, o_cpu_hold_reset, i_cpu_busy};
                default:        o_value_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_cpu_step       <= 1'b0;
            o_cpu_hold_reset <= 1'b0;
            r_step_count     <= '0;
        end
        else
        begin
            o_cpu_step <= 1'b0;     // Single-cycle pulse
            if (w_ctrl_write)
            begin
                o_cpu_hold_reset <= i_value_wdata[CTRL_HOLD_BIT];
                // A step asked for together with hold-reset is dropped
                if (i_value_wdata[CTRL_STEP_BIT] && !i_value_wdata[CTRL_HOLD_BIT] && !i_cpu_busy)
                    o_cpu_step <= 1'b1;
            end

            if (i_step_done)
                r_step_count <= r_step_count + 16'd1;
        end
    end

    a_step_is_pulse: assert property (
        @(posedge i_clk_5mhz) disable iff (!i_reset_n)
        o_cpu_step |=> !o_cpu_step
    );

endmodule

// ==== debugger/debugger_cmd.sv ====
module debugger_cmd #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic        i_clk_5mhz,
    input  logic        i_reset_n,

    input  logic        i_rx_dv,
    input  logic [7:0]  i_rx_byte,
    output logic        o_tx_dv,
    output logic [7:0]  o_tx_byte,

    output logic        o_mem_en,
    output logic        o_mem_rw,       // 1 read, 0 write
    output logic [15:0] o_mem_addr,
    output logic [7:0]  o_mem_wdata,
    input  logic        i_mem_grant,
    input  logic [7:0]  i_mem_rdata,

    output logic        o_value_en,
    output logic        o_value_we,
    output logic [7:0]  o_value_id,
    output logic [15:0] o_value_wdata,
    input  logic [15:0] i_value_rdata
);

    import debugger_pkg::*;

    localparam logic [15:0] ADDR_MASK = 16'((32'd1 << ADDR_WIDTH) - 1);

    cmd_state_e  r_state;
    cmd_e        r_cmd;
    logic [1:0]  r_remaining;   // Argument bytes still to come
    logic [23:0] r_args;        // Argument bytes, last received in the low byte
    logic [15:0] r_resp;
    logic        w_mem_req;
    logic        w_value_req;

    // Number of argument bytes per opcode, zero for unknown bytes
    function automatic logic [1:0] arg_count(input logic [7:0] op);
        case (cmd_e'(op))
            CMD_MEM_READ:                   return 2'd2;
            CMD_VALUE_READ:                 return 2'd1;
            CMD_MEM_WRITE, CMD_VALUE_WRITE: return 2'd3;
            default:                        return 2'd0;
        endcase
    endfunction

    assign w_mem_req   = (r_state == CS_ISSUE) && (r_cmd inside {CMD_MEM_READ, CMD_MEM_WRITE});
    assign w_value_req = (r_state == CS_ISSUE) && !w_mem_req;

    // Request stays up until the memory grants it
    assign o_mem_en    = w_mem_req;
    assign o_mem_rw    = (r_cmd == CMD_MEM_READ);
    assign o_mem_addr  = ((r_cmd == CMD_MEM_READ) ? r_args[15:0] : r_args[23:8]) & ADDR_MASK;
    assign o_mem_wdata = r_args[7:0];

    assign o_value_en    = w_value_req;
    assign o_value_we    = (r_cmd == CMD_VALUE_WRITE);
    assign o_value_id    = (r_cmd == CMD_VALUE_READ) ? r_args[7:0] : r_args[23:16];
    assign o_value_wdata = r_args[15:0];

    assign o_tx_dv   = (r_state == CS_SEND_HI) || (r_state == CS_SEND_LO);
    assign o_tx_byte = (r_state == CS_SEND_HI) ? r_resp[15:8] : r_resp[7:0];

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            r_state     <= CS_OPCODE;
            r_cmd       <= CMD_MEM_READ;
            r_remaining <= '0;
        end
        else
        begin
            case (r_state)
                CS_OPCODE:
                begin
                    if (i_rx_dv && arg_count(i_rx_byte) != 2'd0)
                    begin
                        r_cmd       <= cmd_e'(i_rx_byte);
                        r_remaining <= arg_count(i_rx_byte);
                        r_state     <= CS_ARGS;
                    end
                end
                CS_ARGS:
                begin
                    if (i_rx_dv)
                    begin
                        r_remaining <= r_remaining - 2'd1;
                        if (r_remaining == 2'd1)
                            r_state <= CS_ISSUE;
                    end
                end
                CS_ISSUE:
                begin
                    if (w_value_req)
                        r_state <= (r_cmd == CMD_VALUE_READ) ? CS_SEND_HI : CS_SEND_LO;
                    else if (i_mem_grant)
                        r_state <= (r_cmd == CMD_MEM_READ) ? CS_WAIT : CS_SEND_LO;
                end
                CS_WAIT:    r_state <= CS_SEND_LO;     // Read data lands this cycle
                CS_SEND_HI: r_state <= CS_SEND_LO;
                default:    r_state <= CS_OPCODE;
            endcase
        end
    end

    always_ff @(posedge i_clk_5mhz)
    begin
        if (r_state == CS_ARGS && i_rx_dv)
            r_args <= {r_args[15:0], i_rx_byte};

        if (w_mem_req && i_mem_grant)
            r_resp <= {8'h00, r_args[7:0]};            // Echo of the write data
        if (r_state == CS_WAIT)
            r_resp <= {8'h00, i_mem_rdata};
        if (w_value_req)
            r_resp <= o_value_we ? {8'h00, VALUE_WRITE_ACK} : i_value_rdata;
    end

    // Host waits for the full response before the next command
    a_no_rx_during_tx: assert property (
        @(posedge i_clk_5mhz) disable iff (!i_reset_n)
        o_tx_dv |-> !i_rx_dv
    );

endmodule

// ==== rtl/debugger_top.sv ====
module debugger_top #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic       i_clk_5mhz,
    input  logic       i_reset_n,

    input  logic       i_rx_dv,
    input  logic [7:0] i_rx_byte,
    output logic       o_tx_dv,
    output logic [7:0] o_tx_byte
);

    // Debugger side of the memory
    logic        w_dbg_mem_en;
    logic        w_dbg_mem_rw;
    logic [15:0] w_dbg_mem_addr;
    logic [7:0]  w_dbg_mem_wdata;
    logic [7:0]  w_dbg_mem_rdata;
    logic        w_dbg_mem_grant;

    logic        w_value_en;
    logic        w_value_we;
    logic [7:0]  w_value_id;
    logic [15:0] w_value_wdata;
    logic [15:0] w_value_rdata;

    // CPU bus and state
    logic        w_cpu_mem_en;
    logic        w_cpu_mem_rw;
    logic [15:0] w_cpu_mem_addr;
    logic [7:0]  w_cpu_mem_wdata;
    logic [7:0]  w_cpu_mem_rdata;
    logic [7:0]  w_cpu_a;
    logic [15:0] w_cpu_pc;
    logic [7:0]  w_cpu_ir;
    logic        w_cpu_busy;
    logic        w_cpu_step;
    logic        w_cpu_hold_reset;
    logic        w_step_done;

    debugger_cmd #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) debugger_cmd_inst (
        .i_clk_5mhz     (i_clk_5mhz),
        .i_reset_n      (i_reset_n),
        .i_rx_dv        (i_rx_dv),
        .i_rx_byte      (i_rx_byte),
        .o_tx_dv        (o_tx_dv),
        .o_tx_byte      (o_tx_byte),
        .o_mem_en       (w_dbg_mem_en),
        .o_mem_rw       (w_dbg_mem_rw),
        .o_mem_addr     (w_dbg_mem_addr),
        .o_mem_wdata    (w_dbg_mem_wdata),
        .i_mem_grant    (w_dbg_mem_grant),
        .i_mem_rdata    (w_dbg_mem_rdata),
        .o_value_en     (w_value_en),
        .o_value_we     (w_value_we),
        .o_value_id     (w_value_id),
        .o_value_wdata  (w_value_wdata),
        .i_value_rdata  (w_value_rdata)
    );

    debugger_values debugger_values_inst (
        .i_clk_5mhz       (i_clk_5mhz),
        .i_reset_n        (i_reset_n),
        .i_value_en       (w_value_en),
        .i_value_we       (w_value_we),
        .i_value_id       (w_value_id),
        .i_value_wdata    (w_value_wdata),
        .o_value_rdata    (w_value_rdata),
        .i_cpu_a          (w_cpu_a),
        .i_cpu_pc         (w_cpu_pc),
        .i_cpu_ir         (w_cpu_ir),
        .i_cpu_busy       (w_cpu_busy),
        .i_step_done      (w_step_done),
        .o_cpu_step       (w_cpu_step),
        .o_cpu_hold_reset (w_cpu_hold_reset)
    );

    step_cpu #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) step_cpu_inst (
        .i_clk_5mhz   (i_clk_5mhz),
        .i_reset_n    (i_reset_n),
        .i_step       (w_cpu_step),
        .i_hold_reset (w_cpu_hold_reset),
        .o_mem_en     (w_cpu_mem_en),
        .o_mem_rw     (w_cpu_mem_rw),
        .o_mem_addr   (w_cpu_mem_addr),
        .o_mem_wdata  (w_cpu_mem_wdata),
        .i_mem_rdata  (w_cpu_mem_rdata),
        .o_a          (w_cpu_a),
        .o_pc         (w_cpu_pc),
        .o_ir         (w_cpu_ir),
        .o_busy       (w_cpu_busy),
        .o_step_done  (w_step_done)
    );

    debug_memory #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) debug_memory_inst (
        .i_clk_5mhz  (i_clk_5mhz),
        .i_reset_n   (i_reset_n),
        .i_cpu_en    (w_cpu_mem_en),
        .i_cpu_rw    (w_cpu_mem_rw),
        .i_cpu_addr  (w_cpu_mem_addr),
        .i_cpu_wdata (w_cpu_mem_wdata),
        .o_cpu_rdata (w_cpu_mem_rdata),
        .i_dbg_en    (w_dbg_mem_en),
        .i_dbg_rw    (w_dbg_mem_rw),
        .i_dbg_addr  (w_dbg_mem_addr),
        .i_dbg_wdata (w_dbg_mem_wdata),
        .o_dbg_rdata (w_dbg_mem_rdata),
        .o_dbg_grant (w_dbg_mem_grant)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic o_clk_5mhz,
    output logic o_reset_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 200 ns period
    initial
    begin
        o_clk_5mhz = 1'b0;
        forever #100 o_clk_5mhz = ~o_clk_5mhz;
    end

    initial
    begin
        o_reset_n <= 1'b0;
        repeat (10) @(posedge o_clk_5mhz);
        o_reset_n <= 1'b1;      // Released on an edge like any other input
    end

endmodule

// ==== verif/debugger_checker.sv ====
module debugger_checker (
    input  logic       i_clk_5mhz,
    input  logic       i_reset_n,
    input  logic       i_tx_dv,
    input  logic [7:0] i_tx_byte
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] expect_q [$];
    string      label_q [$];    // What each expected byte is
    string      current_test = "none";
    int         test_errors = 0;
    int         error_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    task automatic expect_byte(input logic [7:0] value, input string label);
        expect_q.push_back(value);
        label_q.push_back(label);
    endtask

    function automatic int pending();
        return expect_q.size();
    endfunction

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        if (expect_q.size() != 0)
        begin
            $display("%s: %0d expected response bytes never arrived", current_test,
                     expect_q.size());
            test_errors = test_errors + 1;
            error_count = error_count + 1;
            expect_q.delete();
            label_q.delete();
        end
        if (test_errors == 0)
        begin
            $display("Test %s: passed", current_test);
            tests_passed = tests_passed + 1;
        end
        else
        begin
            $display("Test %s: %0d failures", current_test, test_errors);
            tests_failed = tests_failed + 1;
        end
    endtask

    // Every response byte is matched against the oldest expectation
    always @(posedge i_clk_5mhz)
    begin : compare_tx
        logic [7:0] expected;
        string      label;
        if (i_reset_n && i_tx_dv)
        begin
            if (expect_q.size() == 0)
            begin
                $display("Unexpected response byte 0x%02h arrived during test %s",
                         i_tx_byte, current_test);
                test_errors = test_errors + 1;
                error_count = error_count + 1;
            end
            else
            begin
                expected = expect_q.pop_front();
                label    = label_q.pop_front();
                if (i_tx_byte !== expected)
                begin
                    $display("FAIL %s (%s): expected 0x%02h, actual 0x%02h",
                             current_test, label, expected, i_tx_byte);
                    test_errors = test_errors + 1;
                    error_count = error_count + 1;
                end
            end
        end
    end

endmodule

// ==== verif/debugger_tb.sv ====
module debugger_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import debugger_pkg::*;

    localparam int ADDR_WIDTH = 8;
    localparam int MEM_DEPTH  = 1 << ADDR_WIDTH;
    localparam int TIMEOUT    = 200;
    localparam int STEP_GAP   = 10;     // Longest step is 7 cycles after its pulse

    logic       clk_5mhz;
    logic       reset_n;
    logic       rx_dv;
    logic [7:0] rx_byte;
    logic       tx_dv;
    logic [7:0] tx_byte;

    // Reference CPU state and memory image
    logic [7:0]  model_mem [MEM_DEPTH];
    logic [7:0]  model_a;
    logic [15:0] model_pc;
    logic [7:0]  model_ir;
    logic [15:0] model_steps;

    logic [15:0] rand_addr [20];
    logic [7:0]  program_image [13];

    tb_clock_gen tb_clock_gen_inst (
        .o_clk_5mhz (clk_5mhz),
        .o_reset_n  (reset_n)
    );

    debugger_top #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) debugger_top_inst (
        .i_clk_5mhz (clk_5mhz),
        .i_reset_n  (reset_n),
        .i_rx_dv    (rx_dv),
        .i_rx_byte  (rx_byte),
        .o_tx_dv    (tx_dv),
        .o_tx_byte  (tx_byte)
    );

    debugger_checker debugger_checker_inst (
        .i_clk_5mhz (clk_5mhz),
        .i_reset_n  (reset_n),
        .i_tx_dv    (tx_dv),
        .i_tx_byte  (tx_byte)
    );

    function automatic logic [ADDR_WIDTH-1:0] mem_index(input logic [15:0] addr);
        return addr[ADDR_WIDTH-1:0];
    endfunction

    // One instruction of the accumulator CPU, operands little-endian
    function automatic void cpu_model_step();
        logic [7:0] op;
        logic [7:0] lo;
        logic [7:0] hi;
        op = model_mem[mem_index(model_pc)];
        lo = model_mem[mem_index(model_pc + 16'd1)];
        hi = model_mem[mem_index(model_pc + 16'd2)];
        model_ir = op;
        case (op)
            OP_LDA_IMM:
            begin
                model_a  = lo;
                model_pc = model_pc + 16'd2;
            end
            OP_ADC_IMM:
            begin
                model_a  = model_a + lo;        // Wraps, no carry
                model_pc = model_pc + 16'd2;
            end
            OP_STA_ABS:
            begin
                model_mem[mem_index({hi, lo})] = model_a;
                model_pc = model_pc + 16'd3;
            end
            OP_JMP_ABS: model_pc = {hi, lo};
            default:    model_pc = model_pc + 16'd1;
        endcase
        model_steps = model_steps + 16'd1;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        @(posedge clk_5mhz);
        rx_dv   <= 1'b1;
        rx_byte <= value;
        @(posedge clk_5mhz);
        rx_dv   <= 1'b0;
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        while (debugger_checker_inst.pending() != 0 && cycles < TIMEOUT)
        begin
            @(negedge clk_5mhz);
            cycles = cycles + 1;
        end
        if (debugger_checker_inst.pending() != 0)
        begin
            $display("Timeout: no complete response within %0d cycles in test %s",
                     TIMEOUT, debugger_checker_inst.current_test);
            $display("Errors found");
            $finish;
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk_5mhz);
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        debugger_checker_inst.expect_byte(data, $sformatf("write ack 0x%04h", addr));
        send_byte(CMD_MEM_WRITE);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
        send_byte(data);
        wait_response();
        model_mem[mem_index(addr)] = data;
    endtask

    task automatic mem_read_check(input logic [15:0] addr);
        debugger_checker_inst.expect_byte(model_mem[mem_index(addr)],
                                          $sformatf("read 0x%04h", addr));
        send_byte(CMD_MEM_READ);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
        wait_response();
    endtask

    task automatic value_read_check(input logic [7:0] id, input logic [15:0] expected);
        debugger_checker_inst.expect_byte(expected[15:8], $sformatf("value %0d hi", id));
        debugger_checker_inst.expect_byte(expected[7:0], $sformatf("value %0d lo", id));
        send_byte(CMD_VALUE_READ);
        send_byte(id);
        wait_response();
    endtask

    task automatic value_write(input logic [7:0] id, input logic [15:0] data);
        debugger_checker_inst.expect_byte(VALUE_WRITE_ACK, $sformatf("value %0d ack", id));
        send_byte(CMD_VALUE_WRITE);
        send_byte(id);
        send_byte(data[15:8]);
        send_byte(data[7:0]);
        wait_response();
    endtask

    task automatic check_cpu_state();
        value_read_check(VAL_A, {8'h00, model_a});
        value_read_check(VAL_PC, model_pc);
        value_read_check(VAL_IR, {8'h00, model_ir});
    endtask

    task automatic step_once();
        value_write(VAL_CONTROL, 16'h0001);
        idle_cycles(STEP_GAP);
        cpu_model_step();
    endtask

    initial
    begin
        int cycles;
        rx_dv       <= 1'b0;
        rx_byte     <= 8'h00;
        model_a     = 8'h00;
        model_pc    = 16'h0000;
        model_ir    = 8'h00;
        model_steps = 16'h0000;
        for (int i = 0; i < MEM_DEPTH; i++)
            model_mem[i] = 8'h00;          // RAM is cleared by reset
        void'($urandom(80313));

        cycles = 0;
        while (!reset_n && cycles < 50)
        begin
            @(posedge clk_5mhz);
            cycles = cycles + 1;
        end
        if (!reset_n)
        begin
            $display("Timeout: reset was not released within 50 cycles");
            $display("Errors found");
            $finish;
        end

        debugger_checker_inst.start_test("reset_values");
        value_read_check(VAL_A, 16'h0000);
        value_read_check(VAL_PC, 16'h0000);
        value_read_check(VAL_IR, 16'h0000);
        value_read_check(VAL_STEP_COUNT, 16'h0000);
        debugger_checker_inst.finish_test();

        debugger_checker_inst.start_test("memory_round_trip");
        for (int i = 0; i < 20; i++)
        begin
            rand_addr[i] = 16'($urandom());
            mem_write(rand_addr[i], 8'($urandom()));
        end
        for (int i = 0; i < 20; i++)
            mem_read_check(rand_addr[i]);   // Repeated addresses give the last write
        debugger_checker_inst.finish_test();

        debugger_checker_inst.start_test("stepping");
        program_image = '{OP_LDA_IMM, 8'h05, OP_ADC_IMM, 8'h07, OP_STA_ABS, 8'h80, 8'h00,
                          OP_ADC_IMM, 8'hFA, 8'hEA, OP_JMP_ABS, 8'h00, 8'h00};
        for (int i = 0; i < 13; i++)
            mem_write(16'(i), program_image[i]);
        for (int i = 0; i < 8; i++)
        begin
            step_once();
            check_cpu_state();
        end
        mem_read_check(16'h0080);
        value_read_check(VAL_STEP_COUNT, 16'd8);
        debugger_checker_inst.finish_test();

        debugger_checker_inst.start_test("hold_reset");
        value_write(VAL_CONTROL, 16'h0002);
        value_write(VAL_CONTROL, 16'h0003);     // Step is dropped while held
        idle_cycles(STEP_GAP);
        model_a  = 8'h00;
        model_pc = 16'h0000;
        model_ir = 8'h00;
        value_read_check(VAL_STEP_COUNT, model_steps);
        check_cpu_state();
        step_once();
        check_cpu_state();
        value_read_check(VAL_STEP_COUNT, model_steps);
        debugger_checker_inst.finish_test();

        debugger_checker_inst.start_test("robustness");
        send_byte(8'h77);
        idle_cycles(20);                        // Any byte here is flagged as stray
        value_read_check(8'h09, 16'h0000);
        value_write(8'h20, 16'h1234);
        debugger_checker_inst.finish_test();

        $display("Summary: %0d tests passed, %0d tests failed, %0d check failures",
                 debugger_checker_inst.tests_passed, debugger_checker_inst.tests_failed,
                 debugger_checker_inst.error_count);
        if (debugger_checker_inst.error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/debugger_pkg.sv
rtl/debug_memory.sv
rtl/step_cpu.sv
debugger/debugger_values.sv
debugger/debugger_cmd.sv
rtl/debugger_top.sv
verif/tb_clock_gen.sv
verif/debugger_checker.sv
verif/debugger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the debugger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module debugger_tb -f verilog.f -o sim_debugger

output=$(./obj_dir/sim_debugger)
echo "$output"

# Pass only when the testbench reports a clean run
echo "$output" | grep -q "No errors"
